// ==== rtg_vectors.txt ====
// Section header: mode word, vblank first (1) or not (0), pixel count
// Pixel line: framebuffer word, expected vga_rgb as {r6, g6, b6}
c000 0 3
f800 3f000
07e0 00fc0
8410 21821
8100 0 3
7c00 3f000
83e0 00fc0
4210 21861
c083 1 9
001f 0003f
ffff 3ffff
0000 00000
f81f 3f03f
07ff 00fff
0841 02082
a554 29aa9
7bef 1e7de
f800 3f000
ffffffff

// ==== verilog.f ====
+incdir+.
rtg_pkg.sv
rtg_fetch_timer.sv
rtg_word_fifo.sv
rtg_pixel_decode.sv
rtg_channel_mix.sv
rtg_vga_out.sv
rtg_video_top.sv
rtg_properties.sv
rtg_tb.sv

// ==== Makefile ====
# Verilator run of the RTG display path testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rtg_tb
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== rtg_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// RTG display path testbench
// Vector driven RTG streams, native and OSD mixing, credits, vertical blank
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rtg_config.svh"

module rtg_tb;

  import rtg_pkg::*;

  logic        clk_114;
  logic        rst_n;
  rtg_mode_t   mode;
  logic        fill_valid = 1'b0;       // Owned by the credit source
  rtg_word_t   fill_word  = '0;
  logic        credit;
  rgb_t        native_rgb;
  sync_t       sync_in;
  logic        hblank;
  logic        vblank;
  logic        osd_window;
  logic        osd_pixel;
  logic        hsyncpol;
  logic        vsyncpol;
  vga_rgb_t    vga_rgb;
  sync_t       vga_sync;
  logic        pix_strobe;

  logic [31:0] vec_mem [0:63];          // Tokens of the vector file
  rtg_word_t   word_q [$];              // Words of the current section
  rtg_word_t   tx_q [$];                // Words waiting for a credit
  vga_rgb_t    exp_q [$];               // Expected pixels in fill order
  int          seed         = 77;
  int          credits      = `RTG_FIFO_DEPTH;
  int          credits_back = 0;
  int          pixels       = 0;        // Words seen at the output
  int          gap          = 0;
  int          fails        = 0;

  rtg_video_top i_dut (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .mode       (mode),
    .fill_valid (fill_valid),
    .fill_word  (fill_word),
    .credit     (credit),
    .native_rgb (native_rgb),
    .sync_in    (sync_in),
    .hblank     (hblank),
    .vblank     (vblank),
    .osd_window (osd_window),
    .osd_pixel  (osd_pixel),
    .hsyncpol   (hsyncpol),
    .vsyncpol   (vsyncpol),
    .vga_rgb    (vga_rgb),
    .vga_sync   (vga_sync),
    .pix_strobe (pix_strobe)
  );

  bind rtg_video_top rtg_properties i_props (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .fill_valid (fill_valid),
    .pop        (pop),                  // Internal fetch strobe
    .credit     (credit),
    .pix_strobe (pix_strobe),
    .mode       (mode)
  );

  initial begin
    clk_114 = 1'b0;
    forever #5 clk_114 = ~clk_114;      // 10 ns period
  end

  // SDRAM side stand-in, spends a credit per word
  always @(negedge clk_114) begin
    fill_valid = 1'b0;
    if (rst_n) begin
      if (credit) begin
        credits++;
        credits_back++;
      end
      if (gap > 0) begin
        gap--;                          // Random idle cycles
      end else if (tx_q.size() > 0 && credits > 0) begin
        fill_word  = tx_q.pop_front();
        fill_valid = 1'b1;
        credits--;
        gap = {$random(seed)} % 4;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare and failure tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    fails++;
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_rgb(input vga_rgb_t got, input vga_rgb_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s, vga_rgb %05h, expected %05h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_sync(input sync_t got, input sync_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s, vga_sync %02b, expected %02b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("FAILED at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Stop on the first failed bound property
  always @(negedge clk_114) begin
    if (i_dut.i_props.fail_cnt != 0) begin
      $display("A bound assertion on the DUT failed");
      abort_run();
    end
  end

  // Overlay rule, blue gets the tinted background
  function automatic vga_rgb_t mix_expect(input rgb_t c, input logic win, input logic px);
    rgb_t m;
    m = c;
    if (win) begin
      m.r = {px ? 2'b11 : 2'b00, c.r[7:2]};
      m.g = {px ? 2'b11 : 2'b00, c.g[7:2]};
      m.b = {px ? 2'b11 : 2'b10, c.b[7:2]};
    end
    return {m.r[7:2], m.g[7:2], m.b[7:2]};    // DAC keeps the top six
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic native_pass(input int n, input bit osd);
    vga_rgb_t rgb_q [$];
    sync_t    syn_q [$];
    hsyncpol = 1'($random(seed));
    vsyncpol = 1'($random(seed));
    for (int i = 0; i < n + 2; i++) begin
      @(negedge clk_114);
      if (i >= 2) begin                  // Two stages deep
        check_rgb(vga_rgb, rgb_q.pop_front(), osd ? "OSD overlay" : "native pass-through");
        check_sync(vga_sync, syn_q.pop_front(), "sync polarity");
      end
      if (i < n) begin
        native_rgb = 24'($random(seed));
        sync_in    = 2'($random(seed));
        osd_window = osd ? 1'($random(seed)) : 1'b0;
        osd_pixel  = 1'($random(seed));
        rgb_q.push_back(mix_expect(native_rgb, osd_window, osd_pixel));
        syn_q.push_back(sync_in ^ {hsyncpol, vsyncpol});
      end
    end
  endtask

  task automatic next_pixel(input string what);
    int t;
    t = 0;
    do begin
      @(negedge clk_114);
      t++;
    end while (!pix_strobe && t < 200);
    if (!pix_strobe) begin
      $display("Timeout: no pixel strobe within 200 cycles in %s", what);
      abort_run();
    end
  endtask

  task automatic drain_credits();
    int t;
    t = 0;
    while (credits != `RTG_FIFO_DEPTH && t < 200) begin
      @(negedge clk_114);
      t++;
    end
    if (credits != `RTG_FIFO_DEPTH) begin
      $display("Timeout: the source never got all of its credits back");
      abort_run();
    end
  endtask

  // Screen stays dark until the last counted line
  task automatic vblank_hold(input int lines);
    for (int l = 0; l < lines; l++) begin
      repeat (3) begin
        @(negedge clk_114);
        check_count(pix_strobe, 0, "pix_strobe during vertical blank");
      end
      sync_in.hsync = 1'b1;             // Rising edge, one line
      @(negedge clk_114);
      sync_in.hsync = 1'b0;
    end
  endtask

  task automatic stream_section(input rtg_mode_t m, input bit vb, input string what);
    vga_rgb_t e;
    mode       = m;
    vblank     = vb;
    sync_in    = '0;
    native_rgb = '0;
    osd_window = 1'b0;
    osd_pixel  = 1'b0;
    while (word_q.size() > 0) begin
      tx_q.push_back(word_q.pop_front());
    end
    @(negedge clk_114);
    vblank = 1'b0;
    if (vb) begin
      vblank_hold(m.vbend);
    end
    while (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      next_pixel(what);
      check_rgb(vga_rgb, e, what);
      pixels++;
    end
    drain_credits();
    check_count(credits_back, pixels, "credits returned versus words consumed");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rtg_mode_t m;
    int        idx;
    int        n;
    int        sections;
    rst_n      = 1'b0;
    mode       = '0;
    native_rgb = '0;
    sync_in    = '0;
    hblank     = 1'b0;
    vblank     = 1'b0;
    osd_window = 1'b0;
    osd_pixel  = 1'b0;
    hsyncpol   = 1'b0;
    vsyncpol   = 1'b0;
    idx        = 0;
    sections   = 0;
    $readmemh("rtg_vectors.txt", vec_mem);
    repeat (10) @(negedge clk_114);
    check_rgb(vga_rgb, '0, "reset value");
    check_sync(vga_sync, '0, "reset value");
    check_count(credit, 0, "credit in reset");
    check_count(pix_strobe, 0, "pix_strobe in reset");
    rst_n = 1'b1;
    native_pass(40, 1'b0);
    native_pass(40, 1'b1);
    while (idx < 60 && vec_mem[idx] != 32'hffff_ffff) begin
      m = rtg_mode_t'(vec_mem[idx][15:0]);
      n = int'(vec_mem[idx + 2]);
      for (int k = 0; k < n; k++) begin
        word_q.push_back(vec_mem[idx + 3 + 2 * k][15:0]);
        exp_q.push_back(vec_mem[idx + 4 + 2 * k][17:0]);
      end
      stream_section(m, vec_mem[idx + 1][0], $sformatf("vector section %0d", sections));
      idx += 3 + 2 * n;
      sections++;
    end
    check_count(sections, 3, "vector sections read");
    if (fails == 0 && i_dut.i_props.fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== rtg_properties.sv ====
////////////////////////////////////////////////////////////////////////////
// RTG display path assertions
// FIFO fill against credits, credit pulse width and native pixel strobe
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rtg_config.svh"

module rtg_properties (
  input logic               clk_114,
  input logic               rst_n,
  input logic               fill_valid,
  input logic               pop,
  input logic               credit,
  input logic               pix_strobe,
  input rtg_pkg::rtg_mode_t mode
);

  int   occ;                            // Shadow FIFO occupancy
  logic ena_off_q;                      // RTG was off last cycle
  int   fail_cnt = 0;                   // Failed properties so far

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      occ       <= 0;
      ena_off_q <= 1'b0;
    end else begin
      occ       <= occ + int'(fill_valid) - int'(pop);
      ena_off_q <= ~mode.rtg_ena;
    end
  end

  a_no_overfill: assert property (@(posedge clk_114) disable iff (!rst_n)
    fill_valid |-> occ < `RTG_FIFO_DEPTH)
    else begin
      fail_cnt++;
      $error("Fill arrived while the FIFO was full");
    end

  // Pops sit at least two clocks apart once a pixel spans two or more
  a_credit_pulse: assert property (@(posedge clk_114) disable iff (!rst_n)
    credit && (mode.pixel_width != '0) |=> !credit)
    else begin
      fail_cnt++;
      $error("Credit held high for two cycles");
    end

  a_native_strobe: assert property (@(posedge clk_114) disable iff (!rst_n)
    ena_off_q |-> pix_strobe)
    else begin
      fail_cnt++;
      $error("Pixel strobe dropped while RTG was off");
    end

endmodule

// ==== rtg_video_top.sv ====
////////////////////////////////////////////////////////////////////////////
// RTG display path top level
// FIFO fed framebuffer video mixed with native video and OSD to VGA
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rtg_config.svh"

module rtg_video_top (
  input  logic               clk_114,
  input  logic               rst_n,
  input  rtg_pkg::rtg_mode_t mode,
  input  logic               fill_valid,   // Word from the SDRAM side
  input  rtg_pkg::rtg_word_t fill_word,
  output logic               credit,       // One per consumed word
  input  rtg_pkg::rgb_t      native_rgb,
  input  rtg_pkg::sync_t     sync_in,
  input  logic               hblank,
  input  logic               vblank,
  input  logic               osd_window,
  input  logic               osd_pixel,
  input  logic               hsyncpol,
  input  logic               vsyncpol,
  output rtg_pkg::vga_rgb_t  vga_rgb,
  output rtg_pkg::sync_t     vga_sync,
  output logic               pix_strobe
);

  import rtg_pkg::*;

  rtg_word_t head;
  logic      not_empty;
  logic      pop;
  logic      rtg_active;
  logic      dec_strobe;
  rgb_t      rtg_rgb;
  wire rgb_t mix_rgb;                   // Driven per channel below

  ////////////////////////////////////////////////////////////////////////////
  // Fetch side
  ////////////////////////////////////////////////////////////////////////////

  rtg_fetch_timer i_timer (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .mode       (mode),
    .hblank     (hblank),
    .vblank     (vblank),
    .hsync      (sync_in.hsync),        // Raw sync for line counting
    .not_empty  (not_empty),
    .pop        (pop),
    .rtg_active (rtg_active)
  );

  rtg_word_fifo i_fifo (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .fill_valid (fill_valid),
    .fill_word  (fill_word),
    .pop        (pop),
    .head       (head),
    .not_empty  (not_empty),
    .credit     (credit)
  );

  rtg_pixel_decode i_decode (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .pop        (pop),
    .head       (head),
    .hi16       (mode.hi16),
    .rtg_rgb    (rtg_rgb),
    .pix_strobe (dec_strobe)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Mixing and output
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 3; i++) begin : g_mix
    localparam int lsb = (2 - i) * `RTG_COLOR_W;     // Red sits on top

    rtg_channel_mix #(
      .chan (color_idx_e'(i))
    ) i_mix (
      .clk_114    (clk_114),
      .rst_n      (rst_n),
      .rtg_active (rtg_active),
      .rtg_c      (rtg_rgb[lsb +: `RTG_COLOR_W]),
      .native_c   (native_rgb[lsb +: `RTG_COLOR_W]),
      .osd_window (osd_window),
      .osd_pixel  (osd_pixel),
      .mix_c      (mix_rgb[lsb +: `RTG_COLOR_W])
    );
  end

  rtg_vga_out i_out (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .mix        (mix_rgb),
    .sync_in    (sync_in),
    .hsyncpol   (hsyncpol),
    .vsyncpol   (vsyncpol),
    .strobe_in  (dec_strobe),
    .rtg_ena    (mode.rtg_ena),
    .vga_rgb    (vga_rgb),
    .vga_sync   (vga_sync),
    .pix_strobe (pix_strobe)
  );

endmodule

// ==== rtg_vga_out.sv ====
////////////////////////////////////////////////////////////////////////////
// RTG VGA output stage
// Sync alignment and polarity, 6-bit truncation, output registers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rtg_config.svh"

module rtg_vga_out (
  input  logic              clk_114,
  input  logic              rst_n,
  input  rtg_pkg::rgb_t     mix,
  input  rtg_pkg::sync_t    sync_in,
  input  logic              hsyncpol,
  input  logic              vsyncpol,
  input  logic              strobe_in,
  input  logic              rtg_ena,
  output rtg_pkg::vga_rgb_t vga_rgb,
  output rtg_pkg::sync_t    vga_sync,
  output logic              pix_strobe
);

  import rtg_pkg::*;

  sync_t sync_d;                        // Matches the mixer stage
  logic  strobe_d;

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      sync_d     <= '0;
      strobe_d   <= 1'b0;
      vga_sync   <= '0;
      vga_rgb    <= '0;
      pix_strobe <= 1'b0;
    end else begin
      sync_d         <= sync_in;
      strobe_d       <= strobe_in;
      vga_sync.hsync <= sync_d.hsync ^ hsyncpol;     // Polarity select
      vga_sync.vsync <= sync_d.vsync ^ vsyncpol;
      vga_rgb.r      <= mix.r[`RTG_COLOR_W-1 -: `RTG_VGA_W];  // Keep the MSBs
      vga_rgb.g      <= mix.g[`RTG_COLOR_W-1 -: `RTG_VGA_W];
      vga_rgb.b      <= mix.b[`RTG_COLOR_W-1 -: `RTG_VGA_W];
      pix_strobe     <= strobe_d | ~rtg_ena;          // Every clock is a pixel natively
    end
  end

endmodule

// ==== rtg_channel_mix.sv ====
////////////////////////////////////////////////////////////////////////////
// RTG colour channel mixer
// Picks RTG or native colour and overlays the OSD for one channel
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rtg_config.svh"

module rtg_channel_mix #(
  parameter rtg_pkg::color_idx_e chan = rtg_pkg::color_red
) (
  input  logic                    clk_114,
  input  logic                    rst_n,
  input  logic                    rtg_active,
  input  logic [`RTG_COLOR_W-1:0] rtg_c,
  input  logic [`RTG_COLOR_W-1:0] native_c,
  input  logic                    osd_window,
  input  logic                    osd_pixel,
  output logic [`RTG_COLOR_W-1:0] mix_c
);

  import rtg_pkg::*;

  localparam logic [1:0] osd_bg = (chan == color_blue) ? 2'b10 : 2'b00;  // Blue tint

  logic [`RTG_COLOR_W-1:0] src_c;
  logic [1:0]              osd_top;

  assign src_c   = rtg_active ? rtg_c : native_c;
  assign osd_top = osd_pixel ? 2'b11 : osd_bg;

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      mix_c <= '0;
    end else if (osd_window) begin
      mix_c <= {osd_top, src_c[`RTG_COLOR_W-1:2]};   // Dimmed picture under OSD
    end else begin
      mix_c <= src_c;
    end
  end

endmodule

// ==== rtg_pixel_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// RTG hi-colour decoder
// Latches the popped word and widens 15/16-bit pixels to RGB888
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rtg_pixel_decode (
  input  logic               clk_114,
  input  logic               rst_n,
  input  logic               pop,
  input  rtg_pkg::rtg_word_t head,
  input  logic               hi16,
  output rtg_pkg::rgb_t      rtg_rgb,
  output logic               pix_strobe
);

  import rtg_pkg::*;

  rtg_word_t word_q;                    // Current pixel

  always_ff @(posedge clk_114) begin
    if (pop) begin
      word_q <= head;
    end
  end

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      pix_strobe <= 1'b0;
    end else begin
      pix_strobe <= pop;                // New pixel this cycle
    end
  end

  // Top bits repeated into the low bits for full-scale white
  always_comb begin
    if (hi16) begin
      rtg_rgb.r = {word_q[15:11], word_q[15:13]};     // 5-6-5
      rtg_rgb.g = {word_q[10:5], word_q[10:9]};
    end else begin
      rtg_rgb.r = {word_q[14:10], word_q[14:12]};     // 5-5-5, bit 15 unused
      rtg_rgb.g = {word_q[9:5], word_q[9:7]};
    end
    rtg_rgb.b = {word_q[4:0], word_q[4:2]};           // Same in both modes
  end

endmodule

// ==== rtg_word_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// RTG framebuffer word FIFO
// Circular buffer with first-word-through head and one credit per pop
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rtg_config.svh"

module rtg_word_fifo (
  input  logic               clk_114,
  input  logic               rst_n,
  input  logic               fill_valid,
  input  rtg_pkg::rtg_word_t fill_word,
  input  logic               pop,
  output rtg_pkg::rtg_word_t head,
  output logic               not_empty,
  output logic               credit
);

  import rtg_pkg::*;

  localparam int depth = `RTG_FIFO_DEPTH;
  localparam int aw    = $clog2(depth);

  rtg_word_t      mem [depth];          // Word storage
  logic [aw-1:0]  wr_ptr;
  logic [aw-1:0]  rd_ptr;
  logic [aw:0]    count;                // 0 to depth
  logic           do_pop;

  assign head      = mem[rd_ptr];       // Oldest word always visible
  assign not_empty = (count != '0);
  assign do_pop    = pop & not_empty;

  always_ff @(posedge clk_114) begin
    if (fill_valid) begin
      mem[wr_ptr] <= fill_word;
    end
  end

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      credit <= do_pop;                 // Slot freed, source may send again
      if (fill_valid) begin
        wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (aw + 1)'(fill_valid) - (aw + 1)'(do_pop);
    end
  end

endmodule

// ==== rtg_fetch_timer.sv ====
////////////////////////////////////////////////////////////////////////////
// RTG fetch timer
// Paces FIFO pops per pixel and stretches vertical blank by line count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rtg_config.svh"

module rtg_fetch_timer (
  input  logic               clk_114,
  input  logic               rst_n,
  input  rtg_pkg::rtg_mode_t mode,
  input  logic               hblank,
  input  logic               vblank,
  input  logic               hsync,
  input  logic               not_empty,
  output logic               pop,
  output logic               rtg_active
);

  logic [`RTG_PIXW_W-1:0]  pix_ctr;     // Compared against pixel_width
  logic [`RTG_VBEND_W-1:0] vb_ctr;      // Lines since vblank
  logic                    vb_flag;     // Manual vertical blank
  logic                    hsync_d;     // For edge detect
  logic                    blank;
  logic                    at_width;

  assign blank    = vb_flag | hblank;
  assign at_width = (pix_ctr == mode.pixel_width);
  assign pop      = mode.rtg_ena & ~blank & not_empty & at_width;  // Fetch strobe

  // Pixel pacing, holds at the count while the FIFO runs dry
  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      pix_ctr    <= '0;
      rtg_active <= 1'b0;
    end else begin
      rtg_active <= mode.rtg_ena & ~blank;             // Lines up with decoder
      if (blank || pop) begin
        pix_ctr <= '0;
      end else if (!at_width) begin
        pix_ctr <= pix_ctr + 1'b1;
      end
    end
  end

  // The OS leaves vblank awkward, so count lines here
  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      vb_flag <= 1'b0;
      vb_ctr  <= '0;
      hsync_d <= 1'b0;
    end else begin
      hsync_d <= hsync;
      if (vblank) begin
        vb_flag <= 1'b1;
        vb_ctr  <= '0;
      end else if (vb_ctr == mode.vbend) begin
        vb_flag <= 1'b0;                               // Active area resumes
      end else if (hsync && !hsync_d) begin
        vb_ctr <= vb_ctr + 1'b1;                       // One per line
      end
    end
  end

endmodule

// ==== rtg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// RTG display path types
// Pixel words, colour triples, syncs and the mode register layout
////////////////////////////////////////////////////////////////////////////

`include "rtg_config.svh"

package rtg_pkg;

  typedef logic [`RTG_WORD_W-1:0] rtg_word_t;  // Raw framebuffer word

  typedef struct packed {
    logic [`RTG_COLOR_W-1:0] r;
    logic [`RTG_COLOR_W-1:0] g;
    logic [`RTG_COLOR_W-1:0] b;
  } rgb_t;                                      // RGB888, red on top

  typedef struct packed {
    logic [`RTG_VGA_W-1:0] r;
    logic [`RTG_VGA_W-1:0] g;
    logic [`RTG_VGA_W-1:0] b;
  } vga_rgb_t;                                  // DAC triple

  typedef struct packed {
    logic hsync;
    logic vsync;
  } sync_t;

  // Mode register as seen by the video path, 16 bits
  typedef struct packed {
    logic                    rtg_ena;           // RTG picture replaces native
    logic                    hi16;              // 5-6-5 when set, else 5-5-5
    logic [2:0]              rsvd;              // Spare
    logic [`RTG_PIXW_W-1:0]  pixel_width;       // Clocks per pixel minus one
    logic [`RTG_VBEND_W-1:0] vbend;             // Blank lines after vblank
  } rtg_mode_t;

  // Channel position, also picks the OSD background colour
  typedef enum logic [1:0] {
    color_red   = 2'd0,
    color_green = 2'd1,
    color_blue  = 2'd2
  } color_idx_e;

endpackage

// ==== rtg_config.svh ====
////////////////////////////////////////////////////////////////////////////
// RTG display path sizing
// FIFO depth, colour widths and the programmable counter widths
////////////////////////////////////////////////////////////////////////////

`ifndef RTG_CONFIG_SVH
`define RTG_CONFIG_SVH

// Framebuffer word FIFO
`define RTG_FIFO_DEPTH 8        // Words held, also the initial credit count
`define RTG_WORD_W     16       // One hi-colour pixel per word

// Colour paths
`define RTG_COLOR_W    8        // Internal channel width
`define RTG_VGA_W      6        // DAC width per channel

// Programmable timing
`define RTG_PIXW_W     4        // Clocks per pixel minus one
`define RTG_VBEND_W    7        // Lines of manual vertical blank

`endif
